// File: bch_dec_top.f
bch_pkg.sv
bch_syndrome.sv
bch_chien.sv
bch_correct.sv
bch_dec_top.sv
bch_dec_top_properties.sv
bch_dec_top_tb.sv

// File: Bender.yml
package:
  name: bch_dec

sources:
  - bch_pkg.sv
  - bch_syndrome.sv
  - bch_chien.sv
  - bch_correct.sv
  - bch_dec_top.sv
  - target: test
    files:
      - bch_dec_top_properties.sv
      - bch_dec_top_tb.sv

// File: bch_dec_top_tb.sv
module bch_dec_top_tb import bch_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N = 15;
	localparam int K = 7;
	localparam int M = field_width(N);
	localparam int ROWS = 12;
	// the generator polynomial of BCH(15,7) is x^8 + x^7 + x^6 + x^4 + 1.
	localparam logic [8:0] GEN = 9'h1D1;
	// the run takes (ROWS + 1) * N + 5 cycles, so this leaves a margin.
	localparam int LIMIT = (ROWS + 2) * N + 20;

	logic clk;
	logic reset;
	logic data_in;
	logic out_valid;
	logic data_out;
	logic out_fail;

	// the stimulus table holds one codeword per row.
	// error positions are given in transmission order.
	bit tab_rand [ROWS];
	logic [K-1:0] tab_msg [ROWS];
	int tab_cnt [ROWS];
	int tab_pos [ROWS][3];

	logic [N-1:0] rx_word [ROWS];
	int exp_cyc [$];
	logic exp_bit [$];
	logic exp_fail [$];
	int checks;
	int errors;
	int missing;

	bch_dec_top #(
		.N(N),
		.K(K)
	) dut0 (
		.clk(clk),
		.reset(reset),
		.data_in(data_in),
		.out_valid(out_valid),
		.data_out(data_out),
		.out_fail(out_fail)
	);

	always #20 clk = ~clk;

	task automatic set_row(input int r, input bit rnd, input logic [K-1:0] msg, input int cnt,
			input int p0, input int p1, input int p2);
		tab_rand[r] = rnd;
		tab_msg[r] = msg;
		tab_cnt[r] = cnt;
		tab_pos[r] = '{p0, p1, p2};
	endtask

	task automatic fill_table();
		set_row(0, 0, 7'h00, 0, 0, 0, 0);
		set_row(1, 0, 7'h5a, 0, 0, 0, 0);
		set_row(2, 1, 7'h00, 1, 0, 0, 0);
		set_row(3, 0, 7'h6c, 1, 6, 0, 0);
		set_row(4, 1, 7'h00, 1, 14, 0, 0);
		set_row(5, 0, 7'h12, 2, 0, 14, 0);
		set_row(6, 1, 7'h00, 2, 5, 6, 0);
		set_row(7, 0, 7'h41, 2, 7, 8, 0);
		// exponents 0, 1 and 4 give 1 + a + a^4 = 0, so S1 cancels.
		set_row(8, 0, 7'h2b, 3, 14, 13, 10);
		set_row(9, 1, 7'h00, 2, 3, 11, 0);
		// the same triple shifted by a^5 also cancels.
		set_row(10, 1, 7'h00, 3, 9, 8, 5);
		set_row(11, 0, 7'h7f, 1, 9, 0, 0);
	endtask

	// the encoding is systematic.
	// the message sits in the top K bits and the parity is the remainder.
	function automatic logic [N-1:0] encode(input logic [K-1:0] msg);
		logic [N-1:0] rem;
		rem = {msg, {(N - K){1'b0}}};
		for (int i = N - 1; i >= N - K; i--) begin
			if (rem[i])
				rem = rem ^ (N'(GEN) << (i - (N - K)));
		end
		return {msg, rem[N-K-1:0]};
	endfunction

	// bit e of the word is the coefficient of x^e, evaluated at alpha^power.
	function automatic logic [M-1:0] syndrome(input logic [N-1:0] word, input int power);
		logic [M-1:0] s;
		s = '0;
		for (int e = 0; e < N; e++) begin
			if (word[e])
				s = s ^ M'(gf_pow(power * e, M));
		end
		return s;
	endfunction

	function automatic err_class_e predict_class(input logic [M-1:0] s1, input logic [M-1:0] s3);
		if (s1 == '0 && s3 == '0)
			return no_err;
		if (s1 == '0)
			return uncorrectable;
		if (s3 == M'(gf_cube(MAX_M'(s1), M)))
			return one_err;
		return two_err;
	endfunction

	// builds every received word and queues the expected output bits with their due cycles.
	task automatic prepare();
		logic [N-1:0] cw;
		bit fail;
		for (int r = 0; r < ROWS; r++) begin
			if (tab_rand[r])
				tab_msg[r] = K'($urandom());
			cw = encode(tab_msg[r]);
			for (int e = 0; e < tab_cnt[r]; e++)
				cw[N - 1 - tab_pos[r][e]] = ~cw[N - 1 - tab_pos[r][e]];
			rx_word[r] = cw;
			fail = (predict_class(syndrome(cw, 1), syndrome(cw, 3)) == uncorrectable);
			for (int j = 0; j < K; j++) begin
				exp_cyc.push_back(r * N + j + N + 2);
				// a word beyond repair comes out exactly as it was received.
				exp_bit.push_back(fail ? cw[N - 1 - j] : tab_msg[r][K - 1 - j]);
				exp_fail.push_back(fail && (j == K - 1));
			end
		end
	endtask

	task automatic drop_overdue(input int cyc);
		while (exp_cyc.size() > 0 && exp_cyc[0] < cyc) begin
			$display("missing output: the bit due in cycle %0d never came out", exp_cyc[0]);
			missing++;
			void'(exp_cyc.pop_front());
			void'(exp_bit.pop_front());
			void'(exp_fail.pop_front());
		end
	endtask

	// outputs are sampled on the falling edge, half a cycle after they were registered.
	task automatic check_outputs(input int cyc);
		drop_overdue(cyc);
		if (out_valid !== 1'b1) begin
			if (out_valid !== 1'b0 || data_out !== 1'b0 || out_fail !== 1'b0) begin
				$display("ERROR at %0t: outputs not low while idle in cycle %0d", $time, cyc);
				errors++;
			end
		end else if (exp_cyc.size() == 0 || exp_cyc[0] != cyc) begin
			$display("ERROR at %0t: unexpected output in cycle %0d", $time, cyc);
			errors++;
		end else begin
			checks++;
			if (data_out !== exp_bit[0] || out_fail !== exp_fail[0]) begin
				$display("ERROR at %0t: cycle %0d gave data %b fail %b, expected %b %b",
					$time, cyc, data_out, out_fail, exp_bit[0], exp_fail[0]);
				errors++;
			end
			void'(exp_cyc.pop_front());
			void'(exp_bit.pop_front());
			void'(exp_fail.pop_front());
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		data_in = 1'b0;
		checks = 0;
		errors = 0;
		missing = 0;
		void'($urandom(32'hbadf));
		fill_table();
		prepare();
		// reset covers three rising edges, and the outputs must read low after each.
		for (int i = 0; i < 3; i++) begin
			@(negedge clk);
			if (out_valid !== 1'b0 || data_out !== 1'b0 || out_fail !== 1'b0) begin
				$display("ERROR at %0t: outputs not low during reset", $time);
				errors++;
			end
		end
		reset = 1'b0;
		// codewords go in back to back, one bit per cycle starting at cycle 0.
		for (int cyc = 0; cyc < ROWS * N + N + 2; cyc++) begin
			if (cyc > 0)
				@(negedge clk);
			check_outputs(cyc);
			data_in = (cyc < ROWS * N) ? rx_word[cyc / N][N - 1 - cyc % N] : 1'b0;
		end
		drop_overdue(ROWS * N + N + 2);
		$display("checks %0d, errors %0d, missing %0d, assertion failures %0d",
			checks, errors, missing, dut0.props0.fails);
		if (errors == 0 && missing == 0 && dut0.props0.fails == 0 && checks == ROWS * K)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin
		int ticks;
		ticks = 0;
		while (ticks < LIMIT) begin
			@(posedge clk);
			ticks++;
		end
		$display("timeout: the run did not finish within %0d cycles", LIMIT);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: bch_dec_top_properties.sv
module bch_dec_top_properties #(
	parameter int N = 15,
	parameter int K = 7
) (
	input logic clk,
	input logic reset,
	input logic out_valid,
	input logic out_fail
);

	timeunit 1ns;
	timeprecision 1ps;

	int unsigned since_reset;
	// number of assertion failures so far.
	int fails = 0;

	// counts cycles from the first cycle with reset low and stops once the first output is due.
	always_ff @(posedge clk) begin
		if (reset)
			since_reset <= 0;
		else if (since_reset < N + 2)
			since_reset <= since_reset + 1;
	end

	// the pipeline is N + 2 cycles deep, so nothing can come out earlier.
	quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
		since_reset < N + 2 |-> !out_valid)
		else begin
			$error("out_valid rose before the pipeline had filled");
			fails++;
		end

	// each codeword yields one run of exactly K message bits.
	run_length: assert property (@(posedge clk) disable iff (reset)
		$rose(out_valid) |-> out_valid [*K] ##1 !out_valid)
		else begin
			$error("out_valid run did not last exactly K cycles");
			fails++;
		end

	// codewords arrive back to back, so output runs start one codeword time apart.
	run_spacing: assert property (@(posedge clk) disable iff (reset)
		$rose(out_valid) |-> ##N $rose(out_valid))
		else begin
			$error("out_valid runs are not N cycles apart");
			fails++;
		end

	fail_with_valid: assert property (@(posedge clk) disable iff (reset)
		out_fail |-> out_valid)
		else begin
			$error("out_fail high while out_valid is low");
			fails++;
		end

endmodule

bind bch_dec_top bch_dec_top_properties #(
	.N(N),
	.K(K)
) props0 (
	.clk(clk),
	.reset(reset),
	.out_valid(out_valid),
	.out_fail(out_fail)
);

// File: bch_dec_top.sv
module bch_dec_top import bch_pkg::*; #(
	parameter int N = 15,
	parameter int K = 7
) (
	input logic clk,
	input logic reset,
	input logic data_in,
	output logic out_valid,
	output logic data_out,
	output logic out_fail
);

	localparam int M = field_width(N);

	logic frame_end;
	logic [M-1:0] syn1;
	logic [M-1:0] syn3;
	logic err_flip;
	logic uncorrectable;

	// decode stage.
	// syndromes of the next codeword build up here while the current one is searched.
	bch_syndrome #(
		.N(N)
	) syndrome0 (
		.clk(clk),
		.reset(reset),
		.data_in(data_in),
		.frame_end(frame_end),
		.syn1(syn1),
		.syn3(syn3)
	);

	// execute stage.
	bch_chien #(
		.N(N)
	) chien0 (
		.clk(clk),
		.reset(reset),
		.frame_end(frame_end),
		.syn1(syn1),
		.syn3(syn3),
		.err_flip(err_flip),
		.uncorrectable(uncorrectable)
	);

	// result stage.
	// the output appears N + 2 cycles after each input bit.
	bch_correct #(
		.N(N),
		.K(K)
	) correct0 (
		.clk(clk),
		.reset(reset),
		.data_in(data_in),
		.frame_end(frame_end),
		.err_flip(err_flip),
		.uncorrectable(uncorrectable),
		.out_valid(out_valid),
		.data_out(data_out),
		.out_fail(out_fail)
	);

endmodule

// File: bch_correct.sv
module bch_correct import bch_pkg::*; #(
	parameter int N = 15,
	parameter int K = 7
) (
	input logic clk,
	input logic reset,
	input logic data_in,
	input logic frame_end,
	input logic err_flip,
	input logic uncorrectable,
	output logic out_valid,
	output logic data_out,
	output logic out_fail
);

	localparam int CW = (K > 1) ? $clog2(K) : 1;

	logic [N:0] dly;
	logic start;
	corr_state_e state;
	logic [CW-1:0] out_cnt;
	logic last;

	// raw bits wait N + 1 cycles, which lines them up with err_flip from the search.
	always_ff @(posedge clk) begin
		dly <= {dly[N-1:0], data_in};
	end

	// the message is the leading K bits, so emission stops after K bits.
	assign last = (out_cnt == CW'(K - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= warmup;
			start <= 1'b0;
			out_cnt <= '0;
			out_valid <= 1'b0;
			data_out <= 1'b0;
			out_fail <= 1'b0;
		end else begin
			// start follows frame_end by one cycle, the cycle in which the search loads.
			start <= frame_end;
			out_valid <= (state == emit);
			data_out <= (state == emit) && (dly[N] ^ err_flip);
			// the fail flag rides on the last message bit of the codeword.
			out_fail <= (state == emit) && last && uncorrectable;
			case (state)
				// nothing is emitted before the first codeword has been received.
				warmup: begin
					if (frame_end)
						state <= idle;
				end
				idle: begin
					if (start) begin
						state <= emit;
						out_cnt <= '0;
					end
				end
				emit: begin
					if (last)
						state <= idle;
					else
						out_cnt <= out_cnt + CW'(1);
				end
				default: state <= warmup;
			endcase
		end
	end

endmodule

// File: bch_chien.sv
module bch_chien import bch_pkg::*; #(
	parameter int N = 15
) (
	input logic clk,
	input logic reset,
	input logic frame_end,
	input logic [field_width(N)-1:0] syn1,
	input logic [field_width(N)-1:0] syn3,
	output logic err_flip,
	output logic uncorrectable
);

	localparam int M = field_width(N);

	// the registers hold S1 * alpha^-p and S3 * alpha^-3p, where p is the exponent of the
	// bit under test, so flipping that bit always adds one to both.
	// bit 0 has p = N - 1 and every later bit lowers p by one.
	localparam logic [MAX_M-1:0] INIT1 = gf_pow(1 - N, M);
	localparam logic [MAX_M-1:0] INIT3 = gf_pow(3 * (1 - N), M);
	localparam logic [MAX_M-1:0] STEP1 = gf_pow(1, M);
	localparam logic [MAX_M-1:0] STEP3 = gf_pow(3, M);

	logic load;
	logic [M-1:0] ch1;
	logic [M-1:0] ch3;
	logic [M-1:0] cur1;
	logic [M-1:0] cur3;
	logic [M-1:0] try1;
	logic [M-1:0] try3;
	logic [M-1:0] keep1;
	logic [M-1:0] keep3;
	err_class_e cls;
	err_class_e cur_cls;
	err_class_e try_cls;
	logic flip;

	function automatic logic [M-1:0] mul_m(input logic [M-1:0] a, input logic [MAX_M-1:0] b);
		return M'(gf_mul(MAX_M'(a), b, M));
	endfunction

	// the class rule only asks whether S1 is zero and whether S3 equals S1 cubed.
	// both tests survive the scaling, so the scaled values can be classed directly.
	function automatic err_class_e classify(input logic [M-1:0] s1, input logic [M-1:0] s3);
		logic [M-1:0] cube;
		cube = M'(gf_cube(MAX_M'(s1), M));
		if (s1 == '0) begin
			if (s3 == '0)
				return no_err;
			return bch_pkg::uncorrectable;
		end
		if (s3 == cube)
			return one_err;
		return two_err;
	endfunction

	always_comb begin
		// in the load cycle bit 0 is tested straight from the fresh syndromes.
		if (load) begin
			cur1 = mul_m(syn1, INIT1);
			cur3 = mul_m(syn3, INIT3);
			cur_cls = classify(cur1, cur3);
		end else begin
			cur1 = ch1;
			cur3 = ch3;
			cur_cls = cls;
		end
		try1 = cur1 ^ M'(1);
		try3 = cur3 ^ M'(1);
		try_cls = classify(try1, try3);
		// a word beyond repair is passed through, since any flip would only add damage.
		flip = (cur_cls != bch_pkg::uncorrectable) && (try_cls < cur_cls);
		keep1 = flip ? try1 : cur1;
		keep3 = flip ? try3 : cur3;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			load <= 1'b0;
			ch1 <= '0;
			ch3 <= '0;
			cls <= no_err;
			err_flip <= 1'b0;
			uncorrectable <= 1'b0;
		end else begin
			load <= frame_end;
			// a found error stays removed, so later bits see the reduced count.
			ch1 <= mul_m(keep1, STEP1);
			ch3 <= mul_m(keep3, STEP3);
			cls <= flip ? try_cls : cur_cls;
			err_flip <= flip;
			if (load)
				uncorrectable <= (cur_cls == bch_pkg::uncorrectable);
		end
	end

endmodule

// File: bch_syndrome.sv
module bch_syndrome import bch_pkg::*; #(
	parameter int N = 15
) (
	input logic clk,
	input logic reset,
	input logic data_in,
	output logic frame_end,
	output logic [field_width(N)-1:0] syn1,
	output logic [field_width(N)-1:0] syn3
);

	localparam int M = field_width(N);
	localparam int CW = $clog2(N);

	// evaluation points for S1 and S3.
	localparam logic [MAX_M-1:0] ALPHA1 = gf_pow(1, M);
	localparam logic [MAX_M-1:0] ALPHA3 = gf_pow(3, M);

	logic [CW-1:0] bit_cnt;
	logic [M-1:0] acc1;
	logic [M-1:0] acc3;
	logic [M-1:0] next1;
	logic [M-1:0] next3;

	// the bit counter starts with reset, so the first bit after reset opens a codeword.
	// frame_end marks the cycle that carries the last bit of the codeword.
	assign frame_end = (bit_cnt == CW'(N - 1));

	// horner step.
	// the first bit is the highest coefficient, so after N steps the sum is r(alpha^k).
	assign next1 = M'(gf_mul(MAX_M'(acc1), ALPHA1, M)) ^ {{(M - 1){1'b0}}, data_in};
	assign next3 = M'(gf_mul(MAX_M'(acc3), ALPHA3, M)) ^ {{(M - 1){1'b0}}, data_in};

	always_ff @(posedge clk) begin
		if (reset) begin
			bit_cnt <= '0;
			acc1 <= '0;
			acc3 <= '0;
		end else if (frame_end) begin
			// the accumulators restart at once, so the next codeword is never stalled.
			bit_cnt <= '0;
			acc1 <= '0;
			acc3 <= '0;
		end else begin
			bit_cnt <= bit_cnt + CW'(1);
			acc1 <= next1;
			acc3 <= next3;
		end
	end

	// finished syndromes are parked here for the search stage.
	// they hold for a whole codeword time while the next pair accumulates.
	always_ff @(posedge clk) begin
		if (frame_end) begin
			syn1 <= next1;
			syn3 <= next3;
		end
	end

endmodule

// File: bch_pkg.sv
package bch_pkg;

	// the widest field supported by the decoder is GF(64), for N = 63.
	localparam int MAX_M = 6;

	// error class of a syndrome pair, ordered so that a lower value means fewer errors.
	typedef enum logic [1:0] {
		no_err,
		one_err,
		two_err,
		uncorrectable
	} err_class_e;

	// state of the output sequencer in the result stage.
	typedef enum logic [1:0] {
		warmup,
		idle,
		emit
	} corr_state_e;

	// the code length fixes the field, since N = 2^M - 1 for a primitive BCH code.
	function automatic int field_width(input int n);
		case (n)
			15: return 4;
			31: return 5;
			63: return 6;
			default: return MAX_M;
		endcase
	endfunction

	// primitive polynomial for each field, including the x^M term.
	function automatic logic [MAX_M:0] field_poly(input int m);
		case (m)
			4: return 7'h13;
			5: return 7'h25;
			6: return 7'h43;
			default: return 7'h43;
		endcase
	endfunction

	// the product in GF(2^m) is built by shift and add, taking the msb of b first.
	// both operands must have zero bits above m-1.
	function automatic logic [MAX_M-1:0] gf_mul(input logic [MAX_M-1:0] a,
			input logic [MAX_M-1:0] b, input int m);
		logic [MAX_M:0] poly;
		logic [MAX_M:0] p;
		poly = field_poly(m);
		p = '0;
		for (int i = MAX_M - 1; i >= 0; i--) begin
			if (i < m) begin
				p = p << 1;
				// the polynomial carries bit m, so this also clears the overflow.
				if (p[m])
					p = p ^ poly;
				if (b[i])
					p = p ^ {1'b0, a};
			end
		end
		return p[MAX_M-1:0];
	endfunction

	// alpha to the power e, where e may be negative and is taken modulo 2^m - 1.
	function automatic logic [MAX_M-1:0] gf_pow(input int e, input int m);
		int n;
		int r_e;
		logic [MAX_M-1:0] r;
		n = (1 << m) - 1;
		r_e = ((e % n) + n) % n;
		r = MAX_M'(1);
		for (int i = 0; i < (1 << MAX_M) - 1; i++) begin
			if (i < r_e)
				r = gf_mul(r, MAX_M'(2), m);
		end
		return r;
	endfunction

	// the cube is compared against S3 to tell one error from two.
	function automatic logic [MAX_M-1:0] gf_cube(input logic [MAX_M-1:0] a, input int m);
		return gf_mul(gf_mul(a, a, m), a, m);
	endfunction

endpackage
